// File: snoop_top.f
snoop_pkg.sv
snoop_ac_recv.sv
snoop_queue.sv
snoop_data_buf.sv
dvm_queue.sv
snoop_resp.sv
snoop_top.sv
tb_snoop_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_snoop_top
FILELIST  ?= snoop_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_snoop_top.sv
/*
 * Testbench for the snoop unit
 * Random snoops, DVM messages, fills and back-pressure, checked against a
 * mirror of the line table
 */
module tb_snoop_top
  import snoop_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_OPS  = 400;
  localparam int          WAIT_MAX = 2000;
  localparam logic [31:0] SEED     = 32'd10135;

  logic      forever_cpuclk = 1'b0;
  logic      rst_n          = 1'b0;
  logic      ac_valid       = 1'b0;
  logic      ac_ready;
  ac_req_t   ac_req         = '0;
  logic      cr_valid;
  logic      cr_ready       = 1'b0;
  cr_resp_t  cr_resp;
  logic      cd_valid;
  logic      cd_ready       = 1'b0;
  cd_pkt_t   cd_pkt;
  logic      fill_valid     = 1'b0;
  fill_req_t fill_req       = '0;
  logic      snoop_busy;

  // Stimulus and back-pressure streams
  logic [31:0] rng;
  logic [31:0] bp_rng = SEED ^ 32'h5a5a_0f0f;

  // Four tags per index, low tag bits keep them distinct
  logic [31:0] tag_pool [4][4];
  snoop_addr_t last_addr = '0;

  // Line table mirror and expected traffic
  line_tag_t   m_tag   [4];
  line_state_e m_state [4] = '{INVALID, INVALID, INVALID, INVALID};
  line_data_t  m_data  [4];
  cr_resp_t    exp_cr [$];
  cd_pkt_t     exp_cd [$];
  cr_resp_t    e_cr;
  cd_pkt_t     e_cd;
  int          n_cr = 0;
  int          n_cd = 0;

  snoop_top #(
    .DVM_DEPTH (2)
  ) dut (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .ac_valid       (ac_valid),
    .ac_ready       (ac_ready),
    .ac_req         (ac_req),
    .cr_valid       (cr_valid),
    .cr_ready       (cr_ready),
    .cr_resp        (cr_resp),
    .cd_valid       (cd_valid),
    .cd_ready       (cd_ready),
    .cd_pkt         (cd_pkt),
    .fill_valid     (fill_valid),
    .fill_req       (fill_req),
    .snoop_busy     (snoop_busy)
  );

  always #50 forever_cpuclk = ~forever_cpuclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("[FAIL] %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Ready bits change each cycle, mostly high
  always @(posedge forever_cpuclk) begin
    #1;
    bp_rng   = xorshift32(bp_rng);
    cr_ready = (bp_rng[2:0] > 3'd1);
    cd_ready = (bp_rng[6:4] > 3'd2);
  end

  task automatic model_fill(input fill_req_t f);
    line_idx_t idx;
    idx          = f.addr[7:6];
    m_tag[idx]   = f.addr[39:8];
    m_state[idx] = f.state;
    m_data[idx]  = f.data;
  endtask

  // Expected response and beats for one accepted request
  task automatic model_accept(input ac_req_t r);
    line_idx_t   idx;
    logic        hit;
    logic        uniq;
    logic        dirty;
    cr_resp_t    resp;
    cd_pkt_t     pkt;
    idx   = r.addr[7:6];
    hit   = (m_state[idx] != INVALID) && (m_tag[idx] == r.addr[39:8]);
    uniq  = (m_state[idx] == UNIQUE_CLEAN) || (m_state[idx] == UNIQUE_DIRTY);
    dirty = (m_state[idx] == UNIQUE_DIRTY);
    resp  = '0;
    if (r.snoop != DVM_OP && hit) begin
      resp.was_unique = uniq;
      case (r.snoop)
        READ_SHARED: begin
          resp.data_transfer = 1'b1;
          resp.is_shared     = 1'b1;
          resp.pass_dirty    = dirty;
          m_state[idx]       = SHARED_CLEAN;
        end
        READ_UNIQUE: begin
          resp.data_transfer = 1'b1;
          resp.pass_dirty    = dirty;
          m_state[idx]       = INVALID;
        end
        CLEAN_INVALID: begin
          // Clean lines are dropped without data
          resp.data_transfer = dirty;
          resp.pass_dirty    = dirty;
          m_state[idx]       = INVALID;
        end
        MAKE_INVALID: begin
          m_state[idx] = INVALID;
        end
        default: begin
          resp = '0;
        end
      endcase
    end
    exp_cr.push_back(resp);
    if (resp.data_transfer) begin
      for (int b = 0; b < 4; b++) begin
        pkt.data = m_data[idx][b*128 +: 128];
        pkt.last = (b == 3);
        exp_cd.push_back(pkt);
      end
    end
  endtask

  // Sampled mid-cycle, values hold until the next rising edge
  always @(negedge forever_cpuclk) begin
    if (rst_n) begin
      if (fill_valid) begin
        model_fill(fill_req);
      end
      if (ac_valid && ac_ready) begin
        model_accept(ac_req);
      end
      if (cr_valid && cr_ready) begin
        if (exp_cr.size() == 0) begin
          stop_on_error("A snoop response arrived that no request asked for");
        end
        e_cr = exp_cr.pop_front();
        check_value($sformatf("cr response %0d", n_cr), 256'(e_cr), 256'(cr_resp));
        n_cr++;
      end
      if (cd_valid && cd_ready) begin
        if (exp_cd.size() == 0) begin
          stop_on_error("A data beat arrived that no response announced");
        end
        e_cd = exp_cd.pop_front();
        check_value($sformatf("cd beat %0d", n_cd), 256'(e_cd), 256'(cd_pkt));
        n_cd++;
      end
    end
  end

  task automatic send_req(input snoop_addr_t addr, input ac_snoop_e snoop);
    int   n;
    logic done;
    n            = 0;
    done         = 1'b0;
    ac_valid     = 1'b1;
    ac_req.addr  = addr;
    ac_req.snoop = snoop;
    last_addr    = addr;
    while (!done) begin
      @(negedge forever_cpuclk);
      if (ac_ready) begin
        done = 1'b1;
      end else begin
        n++;
        if (n > WAIT_MAX) begin
          stop_on_error("Timed out waiting for ac_ready to accept a request");
        end
      end
      @(posedge forever_cpuclk);
      #1;
    end
    ac_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge forever_cpuclk);
      if (!snoop_busy) begin
        done = 1'b1;
      end else begin
        n++;
        if (n > WAIT_MAX) begin
          stop_on_error("Timed out waiting for snoop_busy to fall before a fill");
        end
      end
      @(posedge forever_cpuclk);
      #1;
    end
  endtask

  // Fill one entry with fresh random data, table must be quiet
  task automatic fill_line(input line_idx_t idx, input line_tag_t tag,
                           input line_state_e state);
    wait_idle();
    fill_valid     = 1'b1;
    fill_req.addr  = {tag, idx, 6'd0};
    fill_req.state = state;
    for (int w = 0; w < 16; w++) begin
      rng = xorshift32(rng);
      fill_req.data[w*32 +: 32] = rng;
    end
    @(posedge forever_cpuclk);
    #1;
    fill_valid = 1'b0;
  endtask

  // Random type, DVM about one time in eight
  function automatic ac_snoop_e pick_type(input logic [2:0] t, input logic allow_dvm);
    if (t == 3'd4 && allow_dvm) begin
      return DVM_OP;
    end
    return ac_snoop_e'({1'b0, t[1:0]});
  endfunction

  task automatic send_random_snoop();
    line_idx_t   idx;
    snoop_addr_t addr;
    rng  = xorshift32(rng);
    idx  = rng[1:0];
    addr = {tag_pool[idx][rng[3:2]], idx, rng[9:4]};
    // Follow-up to the previous line to see its new state
    if (rng[12:11] == 2'd0) begin
      addr = last_addr;
    end
    send_req(addr, pick_type(rng[15:13], 1'b1));
    if (rng[16]) begin
      @(posedge forever_cpuclk);
      #1;
    end
  endtask

  // Nothing held anywhere in the unit
  task automatic wait_drain();
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge forever_cpuclk);
      #2;
      if (!snoop_busy) begin
        done = 1'b1;
      end else begin
        n++;
        if (n > WAIT_MAX) begin
          stop_on_error("Timed out waiting for snoop_busy to fall at the end of the run");
        end
      end
    end
  endtask

  initial begin
    rng = SEED;
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 4; k++) begin
        rng = xorshift32(rng);
        tag_pool[i][k] = {rng[31:2], 2'(k)};
      end
    end

    repeat (3) @(posedge forever_cpuclk);
    #1;
    rst_n = 1'b1;

    // Idle outputs after reset
    @(negedge forever_cpuclk);
    check_value("reset ac_ready", 256'(1), 256'(ac_ready));
    check_value("reset cr_valid", 256'(0), 256'(cr_valid));
    check_value("reset cd_valid", 256'(0), 256'(cd_valid));
    check_value("reset snoop_busy", 256'(0), 256'(snoop_busy));
    @(posedge forever_cpuclk);
    #1;

    // Empty table, every lookup misses
    repeat (12) send_random_snoop();

    // Valid entries but wrong tags
    for (int i = 0; i < 4; i++) begin
      fill_line(2'(i), tag_pool[i][0], UNIQUE_DIRTY);
    end
    for (int j = 0; j < 12; j++) begin
      rng = xorshift32(rng);
      send_req({tag_pool[rng[1:0]][2'd1 + 2'(rng[3:2] % 3)], rng[1:0], rng[9:4]},
               pick_type(rng[12:10], 1'b0));
    end

    // Mixed fills, snoops and DVM messages
    for (int i = 0; i < NUM_OPS; i++) begin
      rng = xorshift32(rng);
      if (rng[3:0] < 4'd3) begin
        fill_line(rng[5:4], tag_pool[rng[5:4]][rng[7:6]], line_state_e'(rng[9:8]));
      end else begin
        send_random_snoop();
      end
    end

    wait_drain();
    // Quiet period catches duplicated responses or beats
    repeat (20) @(posedge forever_cpuclk);
    check_value("cr queue left over", 256'(0), 256'(exp_cr.size()));
    check_value("cd queue left over", 256'(0), 256'(exp_cd.size()));

    $display("%0d responses and %0d data beats checked", n_cr, n_cd);
    $display("Everything OK");
    $finish;
  end

endmodule

// File: snoop_top.sv
/*
 * Snoop unit top level
 * Address channel receiver, snoop queue, DVM queue, data buffer and
 * response merge
 */
module snoop_top
  import snoop_pkg::*;
#(
  parameter int DVM_DEPTH = snoop_pkg::DVM_DEPTH
) (
  input  logic      forever_cpuclk,
  input  logic      rst_n,
  input  logic      ac_valid,
  output logic      ac_ready,
  input  ac_req_t   ac_req,
  output logic      cr_valid,
  input  logic      cr_ready,
  output cr_resp_t  cr_resp,
  output logic      cd_valid,
  input  logic      cd_ready,
  output cd_pkt_t   cd_pkt,
  input  logic      fill_valid,
  input  fill_req_t fill_req,
  output logic      snoop_busy
);

  // Receiver to queues
  logic       snq_valid;
  logic       snq_ready;
  ac_req_t    snq_req;
  logic       dvm_valid;
  logic       dvm_ready;
  logic       snq_idle;
  logic       dvm_empty;
  logic       recv_busy;

  // Queues to merge
  logic       snq_cr_valid;
  cr_resp_t   snq_cr_resp;
  logic       dvm_cr_valid;
  cr_resp_t   dvm_cr_resp;
  logic       src_cr_ready;

  // Line handoff and data beats
  logic       line_valid;
  logic       line_ready;
  line_data_t line_data;
  logic       sdb_cd_valid;
  logic       sdb_cd_ready;
  cd_pkt_t    sdb_cd_pkt;
  logic       sdb_busy;

  snoop_ac_recv u_ac_recv (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .ac_valid       (ac_valid),
    .ac_ready       (ac_ready),
    .ac_req         (ac_req),
    .snq_valid      (snq_valid),
    .snq_ready      (snq_ready),
    .snq_req        (snq_req),
    .dvm_valid      (dvm_valid),
    .dvm_ready      (dvm_ready),
    .snq_idle       (snq_idle),
    .dvm_empty      (dvm_empty),
    .busy           (recv_busy)
  );

  snoop_queue u_snq (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .req_valid      (snq_valid),
    .req_ready      (snq_ready),
    .req            (snq_req),
    .fill_valid     (fill_valid),
    .fill_req       (fill_req),
    .idle           (snq_idle),
    .cr_valid       (snq_cr_valid),
    .cr_ready       (src_cr_ready),
    .cr_resp        (snq_cr_resp),
    .line_valid     (line_valid),
    .line_ready     (line_ready),
    .line_data      (line_data)
  );

  dvm_queue #(
    .DVM_DEPTH (DVM_DEPTH)
  ) u_dvmq (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .dvm_valid      (dvm_valid),
    .dvm_ready      (dvm_ready),
    .empty          (dvm_empty),
    .cr_valid       (dvm_cr_valid),
    .cr_ready       (src_cr_ready),
    .cr_resp        (dvm_cr_resp)
  );

  snoop_data_buf u_sdb (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .line_valid     (line_valid),
    .line_ready     (line_ready),
    .line_data      (line_data),
    .cd_valid       (sdb_cd_valid),
    .cd_ready       (sdb_cd_ready),
    .cd_pkt         (sdb_cd_pkt),
    .busy           (sdb_busy)
  );

  snoop_resp u_resp (
    .snq_cr_valid (snq_cr_valid),
    .snq_cr_resp  (snq_cr_resp),
    .dvm_cr_valid (dvm_cr_valid),
    .dvm_cr_resp  (dvm_cr_resp),
    .src_cr_ready (src_cr_ready),
    .sdb_cd_valid (sdb_cd_valid),
    .sdb_cd_pkt   (sdb_cd_pkt),
    .sdb_cd_ready (sdb_cd_ready),
    .cr_valid     (cr_valid),
    .cr_ready     (cr_ready),
    .cr_resp      (cr_resp),
    .cd_valid     (cd_valid),
    .cd_ready     (cd_ready),
    .cd_pkt       (cd_pkt)
  );

  // Anything held in any block
  assign snoop_busy = recv_busy || !snq_idle || !dvm_empty || sdb_busy;

endmodule

// File: snoop_resp.sv
/*
 * Snoop response merge
 * Joins snoop queue and DVM queue responses onto one response channel,
 * passes data beats through to the bus
 */
module snoop_resp
  import snoop_pkg::*;
(
  input  logic     snq_cr_valid,
  input  cr_resp_t snq_cr_resp,
  input  logic     dvm_cr_valid,
  input  cr_resp_t dvm_cr_resp,
  output logic     src_cr_ready,
  input  logic     sdb_cd_valid,
  input  cd_pkt_t  sdb_cd_pkt,
  output logic     sdb_cd_ready,
  output logic     cr_valid,
  input  logic     cr_ready,
  output cr_resp_t cr_resp,
  output logic     cd_valid,
  input  logic     cd_ready,
  output cd_pkt_t  cd_pkt
);

  // Sources never overlap, gated OR is enough
  assign cr_valid = snq_cr_valid || dvm_cr_valid;
  assign cr_resp  = cr_resp_t'((snq_cr_resp & {5{snq_cr_valid}})
                             | (dvm_cr_resp & {5{dvm_cr_valid}}));

  // Same ready to both, only the valid one sees a transfer
  assign src_cr_ready = cr_ready;

  // Data channel straight through
  assign cd_valid     = sdb_cd_valid;
  assign cd_pkt       = sdb_cd_pkt;
  assign sdb_cd_ready = cd_ready;

  always_comb begin
    a_one_src: assert (!(snq_cr_valid === 1'b1 && dvm_cr_valid === 1'b1))
      else $error("snoop and DVM responses valid together");
  end

endmodule

// File: dvm_queue.sv
/*
 * DVM message queue
 * Counts outstanding DVM messages and acknowledges each one with an
 * empty snoop response, in arrival order
 */
module dvm_queue
  import snoop_pkg::*;
#(
  parameter int DVM_DEPTH = snoop_pkg::DVM_DEPTH
) (
  input  logic     forever_cpuclk,
  input  logic     rst_n,
  input  logic     dvm_valid,
  output logic     dvm_ready,
  output logic     empty,
  output logic     cr_valid,
  input  logic     cr_ready,
  output cr_resp_t cr_resp
);

  localparam int CNT_W = $clog2(DVM_DEPTH + 1);

  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Room left while below depth
  assign dvm_ready = (count_q < CNT_W'(DVM_DEPTH));
  assign empty     = (count_q == '0);

  assign push = dvm_valid && dvm_ready;
  assign pop  = cr_valid && cr_ready;

  // Every queued message has a pending ack
  assign cr_valid = !empty;
  assign cr_resp  = '0;

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Occupancy stays within depth across push and pop
  a_no_overflow: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    count_q <= CNT_W'(DVM_DEPTH));

  a_ack_hold: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    cr_valid && !cr_ready |=> cr_valid);

endmodule

// File: snoop_data_buf.sv
/*
 * Snoop data buffer
 * Holds one cache line and streams it as four data channel beats,
 * low beat first, with last on the final beat
 */
module snoop_data_buf
  import snoop_pkg::*;
(
  input  logic       forever_cpuclk,
  input  logic       rst_n,
  input  logic       line_valid,
  output logic       line_ready,
  input  line_data_t line_data,
  output logic       cd_valid,
  input  logic       cd_ready,
  output cd_pkt_t    cd_pkt,
  output logic       busy
);

  logic       full_q;
  logic [1:0] beat_q;
  line_data_t line_q;
  logic       load;
  logic       beat_fire;

  // New line only once the previous one is fully sent
  assign line_ready = !full_q;
  assign load       = line_valid && line_ready;
  assign beat_fire  = cd_valid && cd_ready;

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      beat_q <= 2'd0;
    end else if (load) begin
      full_q <= 1'b1;
      beat_q <= 2'd0;
    end else if (beat_fire) begin
      beat_q <= beat_q + 2'd1;
      // Buffer frees after the last beat
      if (cd_pkt.last) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (load) begin
      line_q <= line_data;
    end
  end

  assign cd_valid    = full_q;
  assign cd_pkt.data = line_q[{beat_q, 7'd0} +: 128];
  assign cd_pkt.last = (beat_q == 2'd3);
  assign busy        = full_q;

  // A fresh line never starts with a last beat
  a_first_beat: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    load |=> cd_valid && !cd_pkt.last);

  // Last beat ends the line, nothing more until the next handoff
  a_last_ends: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    beat_fire && cd_pkt.last |=> !cd_valid && line_ready);

  a_beat_hold: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    cd_valid && !cd_ready |=> cd_valid && $stable(cd_pkt));

endmodule

// File: snoop_queue.sv
/*
 * Snoop queue
 * Four-entry line table with lookup FSM, snoop response generation,
 * coherence state update and line handoff to the data buffer
 */
module snoop_queue
  import snoop_pkg::*;
(
  input  logic       forever_cpuclk,
  input  logic       rst_n,
  input  logic       req_valid,
  output logic       req_ready,
  input  ac_req_t    req,
  input  logic       fill_valid,
  input  fill_req_t  fill_req,
  output logic       idle,
  output logic       cr_valid,
  input  logic       cr_ready,
  output cr_resp_t   cr_resp,
  output logic       line_valid,
  input  logic       line_ready,
  output line_data_t line_data
);

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    RESPOND,
    HANDOFF
  } snq_state_e;

  snq_state_e  state_q;
  ac_req_t     req_q;
  cr_resp_t    resp_q;
  cr_resp_t    resp_d;

  // Line table
  line_tag_t   tag_mem   [4];
  line_state_e state_mem [4];
  line_data_t  data_mem  [4];

  line_idx_t   idx;
  line_idx_t   fill_idx;
  line_state_e cur_state;
  line_state_e next_state;
  logic        hit;
  logic        was_unique;
  logic        was_dirty;

  assign idx      = req_q.addr[7:6];
  assign fill_idx = fill_req.addr[7:6];

  assign cur_state  = state_mem[idx];
  assign hit        = (cur_state != INVALID) && (tag_mem[idx] == req_q.addr[39:8]);
  assign was_unique = (cur_state == UNIQUE_CLEAN) || (cur_state == UNIQUE_DIRTY);
  assign was_dirty  = (cur_state == UNIQUE_DIRTY);

  // Response and next line state for the current lookup
  always_comb begin
    resp_d     = '0;
    next_state = cur_state;
    if (hit) begin
      unique case (req_q.snoop)
        READ_SHARED: begin
          resp_d.data_transfer = 1'b1;
          resp_d.is_shared     = 1'b1;
          resp_d.was_unique    = was_unique;
          resp_d.pass_dirty    = was_dirty;
          next_state           = SHARED_CLEAN;
        end
        READ_UNIQUE: begin
          resp_d.data_transfer = 1'b1;
          resp_d.was_unique    = was_unique;
          resp_d.pass_dirty    = was_dirty;
          next_state           = INVALID;
        end
        CLEAN_INVALID: begin
          // Data only leaves when it is dirty
          resp_d.data_transfer = was_dirty;
          resp_d.pass_dirty    = was_dirty;
          resp_d.was_unique    = was_unique;
          next_state           = INVALID;
        end
        MAKE_INVALID: begin
          resp_d.was_unique = was_unique;
          next_state        = INVALID;
        end
        default: begin
          next_state = cur_state;
        end
      endcase
    end
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      unique case (state_q)
        IDLE:    if (req_valid) state_q <= LOOKUP;
        LOOKUP:  state_q <= RESPOND;
        RESPOND: if (cr_ready) state_q <= resp_q.data_transfer ? HANDOFF : IDLE;
        HANDOFF: if (line_ready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge forever_cpuclk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    if (state_q == LOOKUP) begin
      resp_q <= resp_d;
    end
  end

  // Entry states start invalid; fills and lookups never overlap
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        state_mem[i] <= INVALID;
      end
    end else if (fill_valid) begin
      state_mem[fill_idx] <= fill_req.state;
    end else if (state_q == LOOKUP) begin
      state_mem[idx] <= next_state;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (fill_valid) begin
      tag_mem[fill_idx]  <= fill_req.addr[39:8];
      data_mem[fill_idx] <= fill_req.data;
    end
  end

  assign req_ready = (state_q == IDLE);
  assign idle      = (state_q == IDLE);

  assign cr_valid = (state_q == RESPOND);
  assign cr_resp  = resp_q;

  // Data array is untouched by snoops, read in place
  assign line_valid = (state_q == HANDOFF);
  assign line_data  = data_mem[idx];

  a_resp_hold: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    cr_valid && !cr_ready |=> cr_valid && $stable(cr_resp));

endmodule

// File: snoop_ac_recv.sv
/*
 * Snoop address channel receiver
 * One register stage; routes DVM messages to the DVM queue and all other
 * snoops to the snoop queue, keeping responses in request order
 */
module snoop_ac_recv
  import snoop_pkg::*;
(
  input  logic    forever_cpuclk,
  input  logic    rst_n,
  input  logic    ac_valid,
  output logic    ac_ready,
  input  ac_req_t ac_req,
  output logic    snq_valid,
  input  logic    snq_ready,
  output ac_req_t snq_req,
  output logic    dvm_valid,
  input  logic    dvm_ready,
  input  logic    snq_idle,
  input  logic    dvm_empty,
  output logic    busy
);

  logic    full_q;
  ac_req_t req_q;
  logic    is_dvm;
  logic    dispatch;

  assign is_dvm = (req_q.snoop == DVM_OP);

  // Snoop waits for all DVM acks, DVM waits for the snoop queue to drain
  assign snq_valid = full_q && !is_dvm && dvm_empty;
  assign dvm_valid = full_q && is_dvm && snq_idle;
  assign snq_req   = req_q;

  assign dispatch = (snq_valid && snq_ready) || (dvm_valid && dvm_ready);

  // Stage refills in the same cycle it empties
  assign ac_ready = !full_q || dispatch;
  assign busy     = full_q;

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (ac_valid && ac_ready) begin
      full_q <= 1'b1;
    end else if (dispatch) begin
      full_q <= 1'b0;
    end
  end

  // Payload only, no reset
  always_ff @(posedge forever_cpuclk) begin
    if (ac_valid && ac_ready) begin
      req_q <= ac_req;
    end
  end

  // Only one response source may ever be in flight
  a_one_dest: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    !(snq_valid && dvm_valid));

  // Held snoop stays offered, so the DVM queue must not refill meanwhile
  a_snq_hold: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    snq_valid && !snq_ready |=> snq_valid && $stable(snq_req));

endmodule

// File: snoop_pkg.sv
/*
 * Snoop unit shared definitions
 * Address fields, line table types, ACE-style snoop response layout and
 * the payload structs carried on the valid/ready channels
 */
package snoop_pkg;

  // Physical snoop address, index in 7:6, tag in 39:8
  typedef logic [39:0]  snoop_addr_t;
  typedef logic [1:0]   line_idx_t;
  typedef logic [31:0]  line_tag_t;

  // Data channel beat and whole cache line, beat 0 in the low bits
  typedef logic [127:0] cd_beat_t;
  typedef logic [511:0] line_data_t;

  // Default number of outstanding DVM messages
  parameter int DVM_DEPTH = 2;

  // Snoop transaction types seen on the address channel
  typedef enum logic [2:0] {
    READ_SHARED   = 3'd0,
    READ_UNIQUE   = 3'd1,
    CLEAN_INVALID = 3'd2,
    MAKE_INVALID  = 3'd3,
    DVM_OP        = 3'd4
  } ac_snoop_e;

  // Coherence state of one table entry
  typedef enum logic [1:0] {
    INVALID      = 2'd0,
    SHARED_CLEAN = 2'd1,
    UNIQUE_CLEAN = 2'd2,
    UNIQUE_DIRTY = 2'd3
  } line_state_e;

  // Snoop response, bit 4 down to bit 0
  typedef struct packed {
    logic was_unique;
    logic is_shared;
    logic pass_dirty;
    logic error;
    logic data_transfer;
  } cr_resp_t;

  // Address channel request
  typedef struct packed {
    snoop_addr_t addr;
    ac_snoop_e   snoop;
  } ac_req_t;

  // One data channel beat with end of line flag
  typedef struct packed {
    cd_beat_t data;
    logic     last;
  } cd_pkt_t;

  // Line table fill
  typedef struct packed {
    snoop_addr_t addr;
    line_state_e state;
    line_data_t  data;
  } fill_req_t;

endpackage
